// File: pcs_check_pkg.sv
package pcs_check_pkg;

	// Block format of the checked stream
	localparam int NB_DATA = 64;
	localparam int NB_CTRL = 8;

	// One history entry per candidate delay
	localparam int DEPTH = 16;
	localparam int NB_ADDR = $clog2(DEPTH);

	// Delays run from 1 to DEPTH and need one bit more than an address
	localparam int NB_DELAY = NB_ADDR + 1;

	// Counted blocks per candidate window
	localparam int N_BLOCKS = 64;

	// Must hold N_BLOCKS itself, since a full window can be all errors
	localparam int NB_PERIOD = $clog2(N_BLOCKS) + 1;

	// Errors seen after lock
	localparam int NB_ERR = 16;

	// Any non-zero start value works for the xorshift generator
	localparam logic [NB_DATA-1:0] GEN_SEED = 64'h9e37_79b9_7f4a_7c15;

endpackage

// File: shift_memory.sv
module shift_memory
	#(
	parameter type T = logic [pcs_check_pkg::NB_DATA-1:0]
	)
	(
	input  logic                              i_clock,
	input  logic                              i_write_enb,
	input  T                                  i_data,
	input  logic [pcs_check_pkg::NB_ADDR-1:0] i_read_addr,
	input  logic                              i_read_enb,
	output T                                  o_data
	);

	T                                  mem [0:pcs_check_pkg::DEPTH-1];
	logic [pcs_check_pkg::NB_ADDR-1:0] wr_ptr = '0;

	// The write pointer only matters relative to the read age
	always_ff @(posedge i_clock)
	begin
		if (i_write_enb)
		begin
			mem[wr_ptr] <= i_data;
			wr_ptr      <= wr_ptr + pcs_check_pkg::NB_ADDR'(1);
		end
	end

	// Age 0 is the sample written on this same edge
	always_ff @(posedge i_clock)
	begin
		if (i_read_enb)
		begin
			if (i_read_addr == '0)
				o_data <= i_data;
			else
				o_data <= mem[wr_ptr - i_read_addr];
		end
	end

endmodule

// File: tx_pattern_gen.sv
module tx_pattern_gen
	(
	input  logic                              i_clock,
	input  logic                              i_reset,
	input  logic                              i_enable,
	output logic [pcs_check_pkg::NB_DATA-1:0] o_tx_data,
	output logic [pcs_check_pkg::NB_CTRL-1:0] o_tx_ctrl
	);

	logic [pcs_check_pkg::NB_DATA-1:0] state;
	logic [pcs_check_pkg::NB_DATA-1:0] step_a;
	logic [pcs_check_pkg::NB_DATA-1:0] step_b;
	logic [pcs_check_pkg::NB_DATA-1:0] state_nxt;

	// Xorshift64 with the 13, 7, 17 shift triple
	always_comb
	begin
		step_a    = state ^ (state << 13);
		step_b    = step_a ^ (step_a >> 7);
		state_nxt = step_b ^ (step_b << 17);
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			state <= pcs_check_pkg::GEN_SEED;
		else if (i_enable)
			state <= state_nxt;
	end

	assign o_tx_data = state;

	// Low byte of the state rotated by 32 bits
	assign o_tx_ctrl = state[32 +: pcs_check_pkg::NB_CTRL];

endmodule

// File: link_model.sv
module link_model
	(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_enable,
	input  logic [pcs_check_pkg::NB_DELAY-1:0] i_link_delay,
	input  logic                               i_inject_error,
	input  logic [pcs_check_pkg::NB_DATA-1:0]  i_tx_data,
	input  logic [pcs_check_pkg::NB_CTRL-1:0]  i_tx_ctrl,
	output logic [pcs_check_pkg::NB_DATA-1:0]  o_rx_data,
	output logic [pcs_check_pkg::NB_CTRL-1:0]  o_rx_ctrl,
	output logic                               o_rx_valid
	);

	logic [pcs_check_pkg::NB_CTRL+pcs_check_pkg::NB_DATA-1:0] wr_block;
	logic [pcs_check_pkg::NB_CTRL+pcs_check_pkg::NB_DATA-1:0] rd_block;
	logic [pcs_check_pkg::NB_DELAY-1:0]                       delay_m1;
	logic [pcs_check_pkg::NB_DELAY-1:0]                       fill_cnt;
	logic                                                     rx_valid;

	// The registered read already adds one cycle of the delay
	assign delay_m1 = i_link_delay - pcs_check_pkg::NB_DELAY'(1);

	// A strobe corrupts data bit 0 of the block entering on the same edge
	assign wr_block = {i_tx_ctrl, i_tx_data ^ pcs_check_pkg::NB_DATA'(i_inject_error)};

	shift_memory
		#(
		.T(logic [pcs_check_pkg::NB_CTRL+pcs_check_pkg::NB_DATA-1:0])
		)
		u_block_mem
		(
		.i_clock     (i_clock),
		.i_write_enb (i_enable),
		.i_data      (wr_block),
		.i_read_addr (delay_m1[pcs_check_pkg::NB_ADDR-1:0]),
		.i_read_enb  (i_enable),
		.o_data      (rd_block)
		);

	// Output is valid once the first post-reset block reaches the read age
	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			fill_cnt <= '0;
			rx_valid <= 1'b0;
		end
		else if (i_enable && !rx_valid)
		begin
			fill_cnt <= fill_cnt + pcs_check_pkg::NB_DELAY'(1);
			if (fill_cnt == delay_m1)
				rx_valid <= 1'b1;
		end
	end

	assign o_rx_data  = rd_block[pcs_check_pkg::NB_DATA-1:0];
	assign o_rx_ctrl  = rd_block[pcs_check_pkg::NB_DATA +: pcs_check_pkg::NB_CTRL];
	assign o_rx_valid = rx_valid;

endmodule

// File: frame_checker.sv
module frame_checker
	(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_enable,
	input  logic [pcs_check_pkg::NB_DATA-1:0]  i_tx_data,
	input  logic [pcs_check_pkg::NB_CTRL-1:0]  i_tx_ctrl,
	input  logic [pcs_check_pkg::NB_DATA-1:0]  i_rx_data,
	input  logic [pcs_check_pkg::NB_CTRL-1:0]  i_rx_ctrl,
	input  logic                               i_rx_valid,
	output logic                               o_locked,
	output logic [pcs_check_pkg::NB_DELAY-1:0] o_lock_delay,
	output logic                               o_match_data,
	output logic                               o_match_ctrl,
	output logic [pcs_check_pkg::NB_ERR-1:0]   o_error_count
	);

	logic [pcs_check_pkg::NB_DATA-1:0]   hist_data;
	logic [pcs_check_pkg::NB_CTRL-1:0]   hist_ctrl;
	logic [pcs_check_pkg::NB_ADDR-1:0]   read_ptr;
	logic [pcs_check_pkg::NB_ADDR-1:0]   read_ptr_nxt;
	logic [pcs_check_pkg::NB_ADDR-1:0]   best_ptr;
	logic [pcs_check_pkg::NB_PERIOD-1:0] period_cnt;
	logic [pcs_check_pkg::NB_PERIOD-1:0] current_err;
	logic [pcs_check_pkg::NB_PERIOD-1:0] min_err;
	logic [pcs_check_pkg::NB_PERIOD-1:0] window_err;
	logic [pcs_check_pkg::NB_DELAY-1:0]  lock_delay;
	logic [pcs_check_pkg::NB_ERR-1:0]    error_count;
	logic                                locked;
	logic                                data_eq;
	logic                                ctrl_eq;
	logic                                block_err;
	logic                                search_step;
	logic                                window_end;
	logic                                last_window;
	logic                                new_best;

	// The memories are addressed with the next pointer, so the history
	// output always lines up with the pointer of the current cycle
	shift_memory
		#(
		.T(logic [pcs_check_pkg::NB_DATA-1:0])
		)
		u_data_mem
		(
		.i_clock     (i_clock),
		.i_write_enb (i_enable),
		.i_data      (i_tx_data),
		.i_read_addr (read_ptr_nxt),
		.i_read_enb  (i_enable),
		.o_data      (hist_data)
		);

	shift_memory
		#(
		.T(logic [pcs_check_pkg::NB_CTRL-1:0])
		)
		u_ctrl_mem
		(
		.i_clock     (i_clock),
		.i_write_enb (i_enable),
		.i_data      (i_tx_ctrl),
		.i_read_addr (read_ptr_nxt),
		.i_read_enb  (i_enable),
		.o_data      (hist_ctrl)
		);

	assign data_eq   = (hist_data == i_rx_data);
	assign ctrl_eq   = (hist_ctrl == i_rx_ctrl);
	assign block_err = !(data_eq && ctrl_eq);

	assign search_step = i_enable && i_rx_valid && !locked;
	assign window_end  = (period_cnt == pcs_check_pkg::NB_PERIOD'(pcs_check_pkg::N_BLOCKS - 1));
	assign last_window = (read_ptr == pcs_check_pkg::NB_ADDR'(pcs_check_pkg::DEPTH - 1));

	// Count including the current block, so no block is lost at a boundary
	assign window_err = current_err + pcs_check_pkg::NB_PERIOD'(block_err);

	// Only a strictly smaller count wins, so the earliest candidate keeps a tie
	assign new_best = (window_err < min_err);

	always_comb
	begin
		read_ptr_nxt = read_ptr;
		if (i_reset)
			read_ptr_nxt = '0;
		else if (search_step && window_end)
		begin
			if (!last_window)
				read_ptr_nxt = read_ptr + pcs_check_pkg::NB_ADDR'(1);
			else if (!new_best)
				read_ptr_nxt = best_ptr;
		end
	end

	always_ff @(posedge i_clock)
	begin
		read_ptr <= read_ptr_nxt;
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
		begin
			period_cnt  <= '0;
			current_err <= '0;
			min_err     <= '1;
			best_ptr    <= '0;
			locked      <= 1'b0;
			lock_delay  <= '0;
		end
		else if (search_step)
		begin
			if (window_end)
			begin
				period_cnt  <= '0;
				current_err <= '0;
				if (new_best)
				begin
					min_err  <= window_err;
					best_ptr <= read_ptr;
				end
				// On the last window the next pointer is already the winner
				if (last_window)
				begin
					locked     <= 1'b1;
					lock_delay <= pcs_check_pkg::NB_DELAY'(read_ptr_nxt)
						+ pcs_check_pkg::NB_DELAY'(1);
				end
			end
			else
			begin
				period_cnt  <= period_cnt + pcs_check_pkg::NB_PERIOD'(1);
				current_err <= window_err;
			end
		end
	end

	always_ff @(posedge i_clock)
	begin
		if (i_reset)
			error_count <= '0;
		else if (i_enable && i_rx_valid && locked && block_err)
			error_count <= error_count + pcs_check_pkg::NB_ERR'(1);
	end

	assign o_locked      = locked;
	assign o_lock_delay  = lock_delay;
	assign o_match_data  = locked && data_eq;
	assign o_match_ctrl  = locked && ctrl_eq;
	assign o_error_count = error_count;

endmodule

// File: pcs_check_top.sv
module pcs_check_top
	(
	input  logic                               i_clock,
	input  logic                               i_reset,
	input  logic                               i_enable,
	input  logic [pcs_check_pkg::NB_DELAY-1:0] i_link_delay,
	input  logic                               i_inject_error,
	output logic                               o_locked,
	output logic [pcs_check_pkg::NB_DELAY-1:0] o_lock_delay,
	output logic                               o_match_data,
	output logic                               o_match_ctrl,
	output logic [pcs_check_pkg::NB_ERR-1:0]   o_error_count
	);

	logic [pcs_check_pkg::NB_DATA-1:0] tx_data;
	logic [pcs_check_pkg::NB_CTRL-1:0] tx_ctrl;
	logic [pcs_check_pkg::NB_DATA-1:0] rx_data;
	logic [pcs_check_pkg::NB_CTRL-1:0] rx_ctrl;
	logic                              rx_valid;

	tx_pattern_gen
		u_tx_pattern_gen
		(
		.i_clock   (i_clock),
		.i_reset   (i_reset),
		.i_enable  (i_enable),
		.o_tx_data (tx_data),
		.o_tx_ctrl (tx_ctrl)
		);

	link_model
		u_link_model
		(
		.i_clock        (i_clock),
		.i_reset        (i_reset),
		.i_enable       (i_enable),
		.i_link_delay   (i_link_delay),
		.i_inject_error (i_inject_error),
		.i_tx_data      (tx_data),
		.i_tx_ctrl      (tx_ctrl),
		.o_rx_data      (rx_data),
		.o_rx_ctrl      (rx_ctrl),
		.o_rx_valid     (rx_valid)
		);

	// The checker sees the undelayed transmit stream as its reference
	frame_checker
		u_frame_checker
		(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_enable      (i_enable),
		.i_tx_data     (tx_data),
		.i_tx_ctrl     (tx_ctrl),
		.i_rx_data     (rx_data),
		.i_rx_ctrl     (rx_ctrl),
		.i_rx_valid    (rx_valid),
		.o_locked      (o_locked),
		.o_lock_delay  (o_lock_delay),
		.o_match_data  (o_match_data),
		.o_match_ctrl  (o_match_ctrl),
		.o_error_count (o_error_count)
		);

endmodule

// File: tb_clock_gen.sv
module tb_clock_gen
	(
	output logic o_clock,
	output logic o_reset
	);

	timeunit 1ns;
	timeprecision 1ns;

	localparam int HALF_PERIOD  = 50;
	localparam int RESET_CYCLES = 2;

	initial
	begin
		o_clock = 1'b0;
		forever
			#HALF_PERIOD o_clock = ~o_clock;
	end

	// Power-on reset covers the first two rising edges
	initial
	begin
		o_reset <= 1'b1;
		repeat (RESET_CYCLES) @(posedge o_clock);
		o_reset <= 1'b0;
	end

endmodule

// File: tb_pcs_check_assert.sv
module tb_pcs_check_assert
	(
	input logic                               i_clock,
	input logic                               i_reset,
	input logic                               i_locked,
	input logic [pcs_check_pkg::NB_DELAY-1:0] i_lock_delay,
	input logic                               i_match_data,
	input logic                               i_match_ctrl,
	input logic [pcs_check_pkg::NB_ERR-1:0]   i_error_count
	);

	timeunit 1ns;
	timeprecision 1ns;

	// Once locked, only a reset may clear the lock
	locked_held: assert property (@(posedge i_clock) (i_locked && !i_reset) |=> i_locked)
		else $error("o_locked fell without a reset");

	lock_delay_stable: assert property (@(posedge i_clock)
		(i_locked && !i_reset) |=> $stable(i_lock_delay))
		else $error("o_lock_delay changed while locked");

	error_count_rising: assert property (@(posedge i_clock)
		!i_reset |=> (i_error_count >= $past(i_error_count)))
		else $error("o_error_count decreased without a reset");

	// No match is reported during the search
	match_low_unlocked: assert property (@(posedge i_clock)
		!i_locked |-> (!i_match_data && !i_match_ctrl))
		else $error("A match output is high while unlocked");

endmodule

// File: tb_pcs_check.sv
module tb_pcs_check;

	timeunit 1ns;
	timeprecision 1ns;

	// A search takes DEPTH windows of N_BLOCKS valid cycles plus the link fill
	localparam int LOCK_LIMIT     = 1100;
	localparam int TRACK_CYCLES   = 200;
	localparam int TIMEOUT_CYCLES = 5 * LOCK_LIMIT + 500;

	logic                               clock;
	logic                               por_reset;
	logic                               reset_req;
	logic                               reset;
	logic                               enable;
	logic [pcs_check_pkg::NB_DELAY-1:0] link_delay;
	logic                               inject_error;
	logic                               locked;
	logic [pcs_check_pkg::NB_DELAY-1:0] lock_delay;
	logic                               match_data;
	logic                               match_ctrl;
	logic [pcs_check_pkg::NB_ERR-1:0]   error_count;
	logic [31:0]                        lcg_state;
	int                                 cycle_count = 0;

	assign reset = por_reset | reset_req;

	tb_clock_gen
		u_clock_gen
		(
		.o_clock (clock),
		.o_reset (por_reset)
		);

	pcs_check_top
		dut
		(
		.i_clock        (clock),
		.i_reset        (reset),
		.i_enable       (enable),
		.i_link_delay   (link_delay),
		.i_inject_error (inject_error),
		.o_locked       (locked),
		.o_lock_delay   (lock_delay),
		.o_match_data   (match_data),
		.o_match_ctrl   (match_ctrl),
		.o_error_count  (error_count)
		);

	bind pcs_check_top tb_pcs_check_assert
		u_assert
		(
		.i_clock       (i_clock),
		.i_reset       (i_reset),
		.i_locked      (o_locked),
		.i_lock_delay  (o_lock_delay),
		.i_match_data  (o_match_data),
		.i_match_ctrl  (o_match_ctrl),
		.i_error_count (o_error_count)
		);

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state;
	endfunction

	// The upper bits of the LCG are the better distributed ones
	function automatic int random_below(int limit);
		return int'((next_random() >> 16) % 32'(limit));
	endfunction

	task automatic abort_run(string reason);
		$display("%s", reason);
		$display("TEST FAILED");
		$fatal(1, "Simulation stopped on the first failure");
	endtask

	task automatic check_value(string name, logic [63:0] actual, logic [63:0] expected);
		if (actual !== expected)
		begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, name, actual, expected);
			abort_run("An output differs from its expected value");
		end
	endtask

	task automatic check_cleared();
		check_value("o_locked", 64'(locked), 64'(0));
		check_value("o_match_data", 64'(match_data), 64'(0));
		check_value("o_match_ctrl", 64'(match_ctrl), 64'(0));
		check_value("o_error_count", 64'(error_count), 64'(0));
	endtask

	task automatic apply_reset(int delay);
		@(posedge clock);
		reset_req    <= 1'b1;
		link_delay   <= pcs_check_pkg::NB_DELAY'(delay);
		inject_error <= 1'b0;
		repeat (2) @(posedge clock);
		reset_req <= 1'b0;
		@(negedge clock);
	endtask

	// Everything stays cleared until the search has judged all candidates
	task automatic wait_for_lock(int delay);
		int cycles;
		cycles = 0;
		while (locked !== 1'b1)
		begin
			check_cleared();
			cycles = cycles + 1;
			if (cycles > LOCK_LIMIT)
				abort_run($sformatf("o_locked did not rise within %0d cycles", LOCK_LIMIT));
			else
				@(negedge clock);
		end
		check_value("o_lock_delay", 64'(lock_delay), 64'(delay));
	endtask

	task automatic test_reset_state();
		int n;
		@(negedge clock);
		while (reset)
			@(negedge clock);
		for (n = 0; n < 100; n++)
		begin
			check_cleared();
			@(negedge clock);
		end
	endtask

	task automatic test_lock(int delay);
		apply_reset(delay);
		check_cleared();
		wait_for_lock(delay);
	endtask

	task automatic test_tracking();
		int n;
		for (n = 0; n < TRACK_CYCLES; n++)
		begin
			@(negedge clock);
			check_value("o_match_data", 64'(match_data), 64'(1));
			check_value("o_match_ctrl", 64'(match_ctrl), 64'(1));
			check_value("o_error_count", 64'(error_count), 64'(0));
		end
	endtask

	task automatic test_error_injection();
		int strobe_cycles[$];
		int strobes;
		int next_cycle;
		int total;
		int idx;
		int low_count;
		int n;
		strobes    = 2 + random_below(5);
		next_cycle = 4;
		for (n = 0; n < strobes; n++)
		begin
			strobe_cycles.push_back(next_cycle);
			next_cycle = next_cycle + 8 + random_below(20);
		end
		// Leave room for the last corrupted block to cross the link
		total     = next_cycle + 20;
		idx       = 0;
		low_count = 0;
		for (n = 0; n < total; n++)
		begin
			@(posedge clock);
			if (idx < strobes && n == strobe_cycles[idx])
			begin
				inject_error <= 1'b1;
				idx = idx + 1;
			end
			else
				inject_error <= 1'b0;
			@(negedge clock);
			if (!match_data)
				low_count = low_count + 1;
			check_value("o_match_ctrl", 64'(match_ctrl), 64'(1));
		end
		check_value("o_match_data low cycles", 64'(low_count), 64'(strobes));
		check_value("o_error_count", 64'(error_count), 64'(strobes));
	endtask

	task automatic test_relock_random();
		int delay;
		delay = 1 + random_below(15);
		$display("Relock with link delay %0d", delay);
		test_lock(delay);
	endtask

	always @(posedge clock)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
			abort_run($sformatf("The run timed out after %0d cycles", TIMEOUT_CYCLES));
	end

	initial
	begin
		lcg_state     = 32'he8b1d797;
		reset_req    <= 1'b0;
		enable       <= 1'b1;
		link_delay   <= pcs_check_pkg::NB_DELAY'(5);
		inject_error <= 1'b0;
		test_reset_state();
		test_lock(5);
		test_tracking();
		test_error_injection();
		test_lock(1);
		test_lock(15);
		test_relock_random();
		$display("TEST OK");
		$finish;
	end

endmodule

// File: pcs_check_top.f
pcs_check_pkg.sv
shift_memory.sv
tx_pattern_gen.sv
link_model.sv
frame_checker.sv
pcs_check_top.sv
tb_clock_gen.sv
tb_pcs_check_assert.sv
tb_pcs_check.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ns \
	--top-module tb_pcs_check -f pcs_check_top.f -o sim_pcs_check

./obj_dir/sim_pcs_check | tee sim.log

if grep -qx "TEST OK" sim.log; then
	echo "Simulation passed"
else
	echo "Simulation failed, see sim.log"
	exit 1
fi
